// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module pu_slave_spi_tb -Mdir obj_dir

output=$(./obj_dir/Vpu_slave_spi_tb +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$output"

# Exit status comes from this search
printf '%s\n' "$output" | grep -q "TEST RESULT: PASS"

// File: source/byte_position_counter.sv
`timescale 1ns/1ps

module byte_position_counter #(
  parameter int data_width = 32
) (
  input  logic clk,
  input  logic rst,
  input  logic cs_active,
  input  logic byte_done,
  output logic [((data_width / pu_spi_pkg::spi_byte_width) > 1 ?
                 $clog2(data_width / pu_spi_pkg::spi_byte_width) : 1)-1:0] byte_index,
  output logic word_start,
  output logic word_done
);

  localparam int bytes_per_word = data_width / pu_spi_pkg::spi_byte_width;
  localparam int idx_width      = (bytes_per_word > 1) ? $clog2(bytes_per_word) : 1;

  logic last_byte;

  assign last_byte = (byte_index == idx_width'(bytes_per_word - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      byte_index <= '0;
    end else if (!cs_active) begin
      // A partial word is forgotten when cs goes high
      byte_index <= '0;
    end else if (byte_done) begin
      byte_index <= last_byte ? '0 : byte_index + 1'b1;
    end
  end

  assign word_start = (byte_index == '0);
  assign word_done  = byte_done & last_byte;

endmodule

// File: source/pu_slave_spi.sv
`timescale 1ns/1ps

module pu_slave_spi #(
  parameter int data_width  = 32,
  parameter int buf_size    = 6,
  parameter int sync_stages = 2
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              signal_cycle,
  input  logic                              signal_wr,
  input  logic [data_width-1:0]             data_in,
  input  logic                              signal_oe,
  output logic [data_width-1:0]             data_out,
  output logic [pu_spi_pkg::attr_width-1:0] attr_out,
  output logic                              flag_start,
  output logic                              flag_stop,
  input  logic                              mosi,
  output logic                              miso,
  input  logic                              sclk,
  input  logic                              cs
);

  localparam int bytes_per_word = data_width / pu_spi_pkg::spi_byte_width;
  localparam int idx_width      = (bytes_per_word > 1) ? $clog2(bytes_per_word) : 1;

  // Serial side
  logic [7:0]           tx_byte;
  logic [7:0]           rx_byte;
  logic                 byte_done;
  logic                 cs_active;
  logic                 cs_rise;
  logic                 cs_fall;
  logic [idx_width-1:0] byte_index;
  logic                 word_start;
  logic                 word_done;

  // Word side
  logic [data_width-1:0] tx_head;
  logic                  tx_valid;
  logic                  tx_pop;
  logic [data_width-1:0] rx_word;
  logic                  rx_push;
  logic                  bank_sel;
  logic                  spi_done;
  logic                  swap;

  // Bank outputs
  logic [data_width-1:0] tx0_data, tx1_data, rx0_data, rx1_data;
  logic                  tx0_valid, tx1_valid, rx0_valid, rx1_valid;
  logic                  tx0_full, tx1_full, rx0_full, rx1_full;
  logic                  tx0_ovf, tx1_ovf, rx0_ovf, rx1_ovf;

  spi_slave_driver #(
    .sync_stages(sync_stages)
  ) u_driver (
    .clk(clk),
    .rst(rst),
    .sclk(sclk),
    .mosi(mosi),
    .cs(cs),
    .miso(miso),
    .tx_byte(tx_byte),
    .rx_byte(rx_byte),
    .byte_done(byte_done),
    .cs_active(cs_active),
    .cs_rise(cs_rise),
    .cs_fall(cs_fall)
  );

  byte_position_counter #(
    .data_width(data_width)
  ) u_counter (
    .clk(clk),
    .rst(rst),
    .cs_active(cs_active),
    .byte_done(byte_done),
    .byte_index(byte_index),
    .word_start(word_start),
    .word_done(word_done)
  );

  word_byte_path #(
    .data_width(data_width)
  ) u_path (
    .clk(clk),
    .rst(rst),
    .cs_active(cs_active),
    .byte_done(byte_done),
    .byte_index(byte_index),
    .word_start(word_start),
    .word_done(word_done),
    .tx_head(tx_head),
    .tx_valid(tx_valid),
    .tx_pop(tx_pop),
    .tx_byte(tx_byte),
    .rx_byte(rx_byte),
    .rx_word(rx_word),
    .rx_push(rx_push)
  );

  transfer_ctrl u_ctrl (
    .clk(clk),
    .rst(rst),
    .signal_cycle(signal_cycle),
    .cs_rise(cs_rise),
    .cs_fall(cs_fall),
    .cs_active(cs_active),
    .bank_sel(bank_sel),
    .flag_start(flag_start),
    .flag_stop(flag_stop),
    .spi_done(spi_done)
  );

  // ----------------------------------------------------------------------
  // Bank steering
  // With bank_sel at 0 tx0 takes system writes and tx1 feeds SPI,
  // while rx0 takes SPI words and rx1 serves signal_oe
  // ----------------------------------------------------------------------
  assign swap = signal_cycle & ~cs_active;

  spi_word_buffer #(.data_width(data_width), .buf_size(buf_size)) tx_bank0 (
    .clk(clk), .rst(rst),
    .wr(signal_wr & ~bank_sel), .oe(tx_pop & bank_sel), .clear(swap & bank_sel),
    .data_in(data_in), .data_out(tx0_data),
    .valid(tx0_valid), .full(tx0_full), .overflow(tx0_ovf)
  );

  spi_word_buffer #(.data_width(data_width), .buf_size(buf_size)) tx_bank1 (
    .clk(clk), .rst(rst),
    .wr(signal_wr & bank_sel), .oe(tx_pop & ~bank_sel), .clear(swap & ~bank_sel),
    .data_in(data_in), .data_out(tx1_data),
    .valid(tx1_valid), .full(tx1_full), .overflow(tx1_ovf)
  );

  spi_word_buffer #(.data_width(data_width), .buf_size(buf_size)) rx_bank0 (
    .clk(clk), .rst(rst),
    .wr(rx_push & ~bank_sel), .oe(signal_oe & bank_sel), .clear(swap & bank_sel),
    .data_in(rx_word), .data_out(rx0_data),
    .valid(rx0_valid), .full(rx0_full), .overflow(rx0_ovf)
  );

  spi_word_buffer #(.data_width(data_width), .buf_size(buf_size)) rx_bank1 (
    .clk(clk), .rst(rst),
    .wr(rx_push & bank_sel), .oe(signal_oe & ~bank_sel), .clear(swap & ~bank_sel),
    .data_in(rx_word), .data_out(rx1_data),
    .valid(rx1_valid), .full(rx1_full), .overflow(rx1_ovf)
  );

  assign tx_head  = bank_sel ? tx0_data  : tx1_data;
  assign tx_valid = bank_sel ? tx0_valid : tx1_valid;
  assign data_out = bank_sel ? rx0_data  : rx1_data;

  // Status merges the read bank with the system write bank
  assign attr_out[pu_spi_pkg::attr_valid]    = bank_sel ? rx0_valid : rx1_valid;
  assign attr_out[pu_spi_pkg::attr_full]     = (bank_sel ? rx0_full : rx1_full)
                                             | (bank_sel ? tx1_full : tx0_full);
  assign attr_out[pu_spi_pkg::attr_spi_done] = spi_done;
  assign attr_out[pu_spi_pkg::attr_overflow] = (bank_sel ? rx0_ovf : rx1_ovf)
                                             | (bank_sel ? tx1_ovf : tx0_ovf);

endmodule

// File: source/pu_spi_pkg.sv
package pu_spi_pkg;

  // Serial framing
  localparam int spi_byte_width = 8;

  // ----------------------------------------------------------------------
  // attr_out bit layout
  // ----------------------------------------------------------------------
  localparam int attr_width    = 4;

  // Read bank holds at least one word
  localparam int attr_valid    = 0;
  // Read bank or system write bank has no free slot
  localparam int attr_full     = 1;
  // A transaction has ended since the last swap
  localparam int attr_spi_done = 2;
  // A word was dropped on a full bank since the last swap
  localparam int attr_overflow = 3;

  // ----------------------------------------------------------------------
  // Transaction phase
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    st_idle,
    st_active,
    st_closing
  } ctrl_state_t;

endpackage

// File: source/spi_slave_driver.sv
`timescale 1ns/1ps

module spi_slave_driver #(
  parameter int sync_stages = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       sclk,
  input  logic       mosi,
  input  logic       cs,
  output logic       miso,
  input  logic [7:0] tx_byte,
  output logic [7:0] rx_byte,
  output logic       byte_done,
  output logic       cs_active,
  output logic       cs_rise,
  output logic       cs_fall
);

  // ----------------------------------------------------------------------
  // Pin synchronizers
  // ----------------------------------------------------------------------
  logic [sync_stages-1:0] sclk_sync;
  logic [sync_stages-1:0] mosi_sync;
  logic [sync_stages-1:0] cs_sync;
  logic                   sclk_q;
  logic                   cs_q;
  logic                   sclk_s;
  logic                   mosi_s;
  logic                   cs_s;
  logic                   sclk_rise;
  logic                   sclk_fall;

  // Shift state
  logic [2:0] bit_cnt;
  logic [7:0] tx_shift;
  logic [7:0] rx_shift;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_sync <= '0;
      mosi_sync <= '0;
      cs_sync   <= '1;
      sclk_q    <= 1'b0;
      cs_q      <= 1'b1;
    end else begin
      sclk_sync <= (sclk_sync << 1) | sync_stages'(sclk);
      mosi_sync <= (mosi_sync << 1) | sync_stages'(mosi);
      cs_sync   <= (cs_sync << 1) | sync_stages'(cs);
      sclk_q    <= sclk_s;
      cs_q      <= cs_s;
    end
  end

  assign sclk_s = sclk_sync[sync_stages-1];
  assign mosi_s = mosi_sync[sync_stages-1];
  assign cs_s   = cs_sync[sync_stages-1];

  assign sclk_rise = sclk_s & ~sclk_q;
  assign sclk_fall = ~sclk_s & sclk_q;

  // cs is active low on the pin
  assign cs_active = ~cs_s;
  assign cs_fall   = ~cs_s & cs_q;
  assign cs_rise   = cs_s & ~cs_q;

  // ----------------------------------------------------------------------
  // Mode 0 shifting with sampling on rise and change on fall
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt   <= '0;
      tx_shift  <= '0;
      rx_shift  <= '0;
      rx_byte   <= '0;
      byte_done <= 1'b0;
    end else begin
      byte_done <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (cs_fall) begin
        // First bit must sit on miso before the first rising edge
        tx_shift <= tx_byte;
      end else if (sclk_rise) begin
        rx_shift <= {rx_shift[6:0], mosi_s};
        bit_cnt  <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          rx_byte   <= {rx_shift[6:0], mosi_s};
          byte_done <= 1'b1;
        end
      end else if (sclk_fall) begin
        // Counter wrapped to 0 after the eighth bit, so a new byte starts
        if (bit_cnt == 3'd0) begin
          tx_shift <= tx_byte;
        end else begin
          tx_shift <= tx_shift << 1;
        end
      end
    end
  end

  assign miso = cs_active & tx_shift[7];

endmodule

// File: source/spi_word_buffer.sv
`timescale 1ns/1ps

module spi_word_buffer #(
  parameter int data_width = 32,
  parameter int buf_size   = 6
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr,
  input  logic                  oe,
  input  logic                  clear,
  input  logic [data_width-1:0] data_in,
  output logic [data_width-1:0] data_out,
  output logic                  valid,
  output logic                  full,
  output logic                  overflow
);

  localparam int ptr_width = (buf_size > 1) ? $clog2(buf_size) : 1;
  localparam int cnt_width = $clog2(buf_size + 1);

  logic [data_width-1:0] mem [buf_size];
  logic [ptr_width-1:0]  wr_ptr;
  logic [ptr_width-1:0]  rd_ptr;
  logic [cnt_width-1:0]  count;
  logic                  do_wr;
  logic                  do_rd;

  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    return (ptr == ptr_width'(buf_size - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign valid    = (count != '0);
  assign full     = (count == cnt_width'(buf_size));
  assign do_wr    = wr & ~full;
  assign do_rd    = oe & valid;
  assign data_out = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else if (clear) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
      // Sticky until the bank is cleared at a swap
      if (wr && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

// File: source/transfer_ctrl.sv
`timescale 1ns/1ps

module transfer_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic signal_cycle,
  input  logic cs_rise,
  input  logic cs_fall,
  input  logic cs_active,
  output logic bank_sel,
  output logic flag_start,
  output logic flag_stop,
  output logic spi_done
);

  pu_spi_pkg::ctrl_state_t state;
  logic                    swap;

  // Banks may only trade places while the bus is idle (cs high)
  assign swap = signal_cycle & ~cs_active;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= pu_spi_pkg::st_idle;
      flag_start <= 1'b0;
      flag_stop  <= 1'b0;
    end else begin
      flag_start <= 1'b0;
      flag_stop  <= 1'b0;
      case (state)
        pu_spi_pkg::st_idle: begin
          if (cs_fall) begin
            state      <= pu_spi_pkg::st_active;
            flag_start <= 1'b1;
          end
        end
        pu_spi_pkg::st_active: begin
          if (cs_rise) begin
            state     <= pu_spi_pkg::st_closing;
            flag_stop <= 1'b1;
          end
        end
        pu_spi_pkg::st_closing: begin
          state <= pu_spi_pkg::st_idle;
        end
        default: begin
          state <= pu_spi_pkg::st_idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Bank select and done attribute
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bank_sel <= 1'b0;
      spi_done <= 1'b0;
    end else begin
      if (swap) begin
        bank_sel <= ~bank_sel;
        spi_done <= 1'b0;
      end
      // A transaction ending on the swap cycle still counts
      if (state == pu_spi_pkg::st_active && cs_rise) begin
        spi_done <= 1'b1;
      end
    end
  end

endmodule

// File: source/word_byte_path.sv
`timescale 1ns/1ps

module word_byte_path #(
  parameter int data_width = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cs_active,
  input  logic                  byte_done,
  input  logic [((data_width / pu_spi_pkg::spi_byte_width) > 1 ?
                 $clog2(data_width / pu_spi_pkg::spi_byte_width) : 1)-1:0] byte_index,
  input  logic                  word_start,
  input  logic                  word_done,
  input  logic [data_width-1:0] tx_head,
  input  logic                  tx_valid,
  output logic                  tx_pop,
  output logic [7:0]            tx_byte,
  input  logic [7:0]            rx_byte,
  output logic [data_width-1:0] rx_word,
  output logic                  rx_push
);

  localparam int bw = pu_spi_pkg::spi_byte_width;

  logic [data_width-1:0] tx_word;
  logic                  word_loaded;
  logic                  fetch;
  logic [data_width-1:0] tx_src;
  logic [data_width-1:0] tx_shifted;

  // ----------------------------------------------------------------------
  // Transmit side
  // ----------------------------------------------------------------------
  assign fetch  = cs_active & word_start & ~word_loaded;
  assign tx_pop = fetch & tx_valid;

  // Before the fetch the head is shown directly, so byte 0 is ready at once
  assign tx_src     = word_loaded ? tx_word : (tx_valid ? tx_head : '0);
  assign tx_shifted = tx_src << (bw * int'(byte_index));
  assign tx_byte    = tx_shifted[data_width-1 -: bw];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      word_loaded <= 1'b0;
    end else if (!cs_active || word_done) begin
      word_loaded <= 1'b0;
    end else if (fetch) begin
      word_loaded <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch) begin
      tx_word <= tx_valid ? tx_head : '0;
    end
  end

  // ----------------------------------------------------------------------
  // Receive side
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (byte_done) begin
      rx_word <= (rx_word << bw) | data_width'(rx_byte);
    end
  end

  // One cycle late so the last byte is already in rx_word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_push <= 1'b0;
    end else begin
      rx_push <= word_done;
    end
  end

endmodule

// File: src.f
source/pu_spi_pkg.sv
source/spi_slave_driver.sv
source/spi_word_buffer.sv
source/byte_position_counter.sv
source/word_byte_path.sv
source/transfer_ctrl.sv
source/pu_slave_spi.sv
tests/pu_slave_spi_checker.sv
tests/pu_slave_spi_tb.sv

// File: tests/pu_slave_spi_checker.sv
`timescale 1ns/1ps

module pu_slave_spi_checker #(
  parameter int sync_stages = 2
) (
  input logic clk,
  input logic rst,
  input logic flag_start,
  input logic flag_stop,
  input logic bank_sel,
  input logic cs
);

  int fail_count = 0;

  // ----------------------------------------------------------------------
  // Transaction flags
  // ----------------------------------------------------------------------
  flags_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(flag_start && flag_stop))
    else begin
      $error("flag_start and flag_stop high in the same cycle");
      fail_count++;
    end

  start_one_cycle: assert property (@(posedge clk) disable iff (rst)
    flag_start |=> !flag_start)
    else begin
      $error("flag_start held longer than one cycle");
      fail_count++;
    end

  stop_one_cycle: assert property (@(posedge clk) disable iff (rst)
    flag_stop |=> !flag_stop)
    else begin
      $error("flag_stop held longer than one cycle");
      fail_count++;
    end

  // Banks trade places only while the cs pin was high at the synchronizer input
  swap_when_idle: assert property (@(posedge clk) disable iff (rst)
    $changed(bank_sel) |-> $past(cs, sync_stages + 1))
    else begin
      $error("bank_sel changed during a transaction");
      fail_count++;
    end

endmodule

bind pu_slave_spi pu_slave_spi_checker #(
  .sync_stages(sync_stages)
) chk0 (
  .clk(clk),
  .rst(rst),
  .flag_start(flag_start),
  .flag_stop(flag_stop),
  .bank_sel(bank_sel),
  .cs(cs)
);

// File: tests/pu_slave_spi_tb.sv
`timescale 1ns/1ps

module pu_slave_spi_tb;

  localparam int data_width  = 32;
  localparam int buf_size    = 6;
  // sclk half period in clk cycles
  localparam int half        = 4;
  // Bytes clocked over all transactions (20 + 12 + 26)
  localparam int total_bytes = 58;
  localparam int watchdog_cycles = total_bytes * 16 * half + 2000;

  logic                              clk;
  logic                              rst;
  logic                              signal_cycle;
  logic                              signal_wr;
  logic                              signal_oe;
  logic [data_width-1:0]             data_in;
  logic [data_width-1:0]             data_out;
  logic [pu_spi_pkg::attr_width-1:0] attr_out;
  logic                              flag_start;
  logic                              flag_stop;
  logic                              mosi;
  logic                              miso;
  logic                              sclk;
  logic                              cs;

  // ----------------------------------------------------------------------
  // Bank model of the system write bank, SPI side banks and read bank
  // ----------------------------------------------------------------------
  logic [data_width-1:0] tx_w[$];
  logic [data_width-1:0] tx_s[$];
  logic [data_width-1:0] rx_s[$];
  logic [data_width-1:0] rx_r[$];
  logic                  tx_w_ovf;
  logic                  rx_s_ovf;
  logic                  rx_r_ovf;
  logic                  spi_done;

  // Pending comparisons
  logic [31:0] got_q[$];
  logic [31:0] exp_q[$];
  string       tag_q[$];

  int checks = 0;
  int errors = 0;
  int test_errors = 0;
  int n_start = 0;
  int n_stop = 0;

  pu_slave_spi #(
    .data_width(data_width),
    .buf_size(buf_size),
    .sync_stages(2)
  ) dut0 (
    .clk(clk),
    .rst(rst),
    .signal_cycle(signal_cycle),
    .signal_wr(signal_wr),
    .data_in(data_in),
    .signal_oe(signal_oe),
    .data_out(data_out),
    .attr_out(attr_out),
    .flag_start(flag_start),
    .flag_stop(flag_stop),
    .mosi(mosi),
    .miso(miso),
    .sclk(sclk),
    .cs(cs)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  always @(negedge clk) begin
    if (flag_start) begin
      n_start++;
    end
    if (flag_stop) begin
      n_stop++;
    end
  end

  always @(negedge clk) begin : compare_results
    logic [31:0] got;
    logic [31:0] exp;
    string       tag;
    while (got_q.size() > 0) begin
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      tag = tag_q.pop_front();
      checks++;
      assert (got == exp) else begin
        $display("error at %0t ns: %s is %h, expected %h", $time, tag, got, exp);
        errors++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Reference functions
  // ----------------------------------------------------------------------
  // Byte idx of one transaction in MSB-first order and zero once the bank runs dry
  function automatic logic [7:0] expected_miso(input int idx);
    logic [data_width-1:0] word;
    if (idx / 4 >= tx_s.size()) begin
      return 8'h00;
    end
    word = tx_s[idx / 4];
    return word[data_width - 1 - 8 * (idx % 4) -: 8];
  endfunction

  function automatic logic [3:0] expected_attr();
    logic [3:0] a;
    a = '0;
    a[pu_spi_pkg::attr_valid]    = (rx_r.size() != 0);
    a[pu_spi_pkg::attr_full]     = (rx_r.size() == buf_size) || (tx_w.size() == buf_size);
    a[pu_spi_pkg::attr_spi_done] = spi_done;
    a[pu_spi_pkg::attr_overflow] = rx_r_ovf | tx_w_ovf;
    return a;
  endfunction

  task automatic queue_check(input logic [31:0] got, input logic [31:0] exp, input string tag);
    got_q.push_back(got);
    exp_q.push_back(exp);
    tag_q.push_back(tag);
  endtask

  task automatic check_attr(input string tag);
    @(negedge clk);
    queue_check(32'(attr_out), 32'(expected_attr()), tag);
  endtask

  task automatic write_words(input int n);
    logic [data_width-1:0] w;
    for (int i = 0; i < n; i++) begin
      w = $urandom();
      @(posedge clk);
      signal_wr <= 1'b1;
      data_in   <= w;
      if (tx_w.size() == buf_size) begin
        tx_w_ovf = 1'b1;
      end else begin
        tx_w.push_back(w);
      end
    end
    @(posedge clk);
    signal_wr <= 1'b0;
  endtask

  // Old SPI-side banks are emptied and become the new write banks
  task automatic swap_banks();
    @(posedge clk);
    signal_cycle <= 1'b1;
    @(posedge clk);
    signal_cycle <= 1'b0;
    tx_s = tx_w;
    tx_w.delete();
    tx_w_ovf = 1'b0;
    rx_r = rx_s;
    rx_r_ovf = rx_s_ovf;
    rx_s.delete();
    rx_s_ovf = 1'b0;
    spi_done = 1'b0;
  endtask

  task automatic read_all_words();
    while (rx_r.size() > 0) begin
      @(negedge clk);
      queue_check(data_out, rx_r[0], "data_out");
      queue_check(32'(attr_out), 32'(expected_attr()), "attr_out during read");
      @(posedge clk);
      signal_oe <= 1'b1;
      @(posedge clk);
      signal_oe <= 1'b0;
      rx_r.delete(0);
    end
    check_attr("attr_out after reads");
  endtask

  // SPI master in mode 0 with MSB first
  // cycle_byte places a swap request mid-transfer
  task automatic run_transaction(input int nbytes, input int cycle_byte);
    logic [7:0]            out_b;
    logic [7:0]            in_b;
    logic [data_width-1:0] in_w;
    int                    starts;
    int                    stops;
    starts = n_start;
    stops  = n_stop;
    in_w   = '0;
    @(posedge clk);
    cs <= 1'b0;
    repeat (half) @(posedge clk);
    for (int i = 0; i < nbytes; i++) begin
      if (i == cycle_byte) begin
        signal_cycle <= 1'b1;
        @(posedge clk);
        signal_cycle <= 1'b0;
      end
      out_b = 8'($urandom());
      for (int b = 7; b >= 0; b--) begin
        sclk <= 1'b0;
        mosi <= out_b[b];
        repeat (half - 1) @(posedge clk);
        @(negedge clk);
        in_b[b] = miso;
        @(posedge clk);
        sclk <= 1'b1;
        repeat (half) @(posedge clk);
      end
      queue_check(32'(in_b), 32'(expected_miso(i)), "miso byte");
      in_w = {in_w[data_width-9:0], out_b};
      if (i % 4 == 3) begin
        if (rx_s.size() == buf_size) begin
          rx_s_ovf = 1'b1;
        end else begin
          rx_s.push_back(in_w);
        end
      end
    end
    sclk <= 1'b0;
    repeat (half) @(posedge clk);
    cs <= 1'b1;
    repeat (4 * half) @(posedge clk);
    // The word after the last whole one is prefetched too
    for (int k = 0; k <= nbytes / 4 && tx_s.size() > 0; k++) begin
      tx_s.delete(0);
    end
    spi_done = 1'b1;
    queue_check(n_start - starts, 1, "flag_start pulses");
    queue_check(n_stop - stops, 1, "flag_stop pulses");
  endtask

  task automatic end_test(input string name);
    @(negedge clk);
    @(negedge clk);
    if (errors == test_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    void'($urandom(32'h9f55));
    rst          = 1'b1;
    signal_cycle = 1'b0;
    signal_wr    = 1'b0;
    signal_oe    = 1'b0;
    data_in      = '0;
    mosi         = 1'b0;
    sclk         = 1'b0;
    cs           = 1'b1;
    tx_w_ovf     = 1'b0;
    rx_s_ovf     = 1'b0;
    rx_r_ovf     = 1'b0;
    spi_done     = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    @(negedge clk);
    queue_check(32'(flag_start), 0, "flag_start after reset");
    queue_check(32'(flag_stop), 0, "flag_stop after reset");
    queue_check(32'(attr_out), 0, "attr_out after reset");
    queue_check(32'(miso), 0, "miso after reset");
    end_test("reset state");

    write_words(3);
    swap_banks();
    run_transaction(20, -1);
    end_test("transmit stream");

    check_attr("attr_out before swap");
    swap_banks();
    read_all_words();
    end_test("receive words");

    run_transaction(12, 8);
    check_attr("attr_out after busy swap request");
    end_test("flags and busy swap");

    write_words(buf_size + 2);
    check_attr("attr_out after overfill");
    swap_banks();
    read_all_words();
    run_transaction(buf_size * 4 + 2, -1);
    swap_banks();
    read_all_words();
    end_test("overflow and partial word");

    @(negedge clk);
    $display("checks %0d, errors %0d, assertion failures %0d",
             checks, errors, dut0.chk0.fail_count);
    if (errors == 0 && dut0.chk0.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
